// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the operand queue testbench with Verilator.
# Exit status is zero only when the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f src.f \
  --top-module tb_operand_queue \
  -o tb_operand_queue \
  > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/tb_operand_queue > sim.log 2>&1

grep -q "RESULT: PASS" sim.log \
  && { echo "Simulation passed, see sim.log"; exit 0; } \
  || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== sim/tb_ref.svh ====
////////////////////////////////////////
// Testbench reference model
// Widening factor, output counts and
// expected output words per command
////////////////////////////////////////
`ifndef TB_REF_SVH
`define TB_REF_SVH

// Widening factor, 1 for ConvNone and for unsupported pairs
function automatic int widen_factor(input int ew, input int cv);
  int f;
  f = 1;
  if ((cv == ConvSExt2 || cv == ConvZExt2) && (ew == EW8 || ew == EW16 || ew == EW32)) f = 2;
  if ((cv == ConvSExt4 || cv == ConvZExt4) && (ew == EW8 || ew == EW16)) f = 4;
  if ((cv == ConvSExt8 || cv == ConvZExt8) && ew == EW8) f = 8;
  return f;
endfunction

// Source elements used up by one output word
function automatic int elems_per_output(input int ew, input int cv);
  return 64 / ((8 << ew) * widen_factor(ew, cv));
endfunction

function automatic int output_count(input int ew, input int cv, input int vl);
  int e;
  e = elems_per_output(ew, cv);
  return (vl + e - 1) / e;
endfunction

// Output word for one part of a source word, elements in natural order
function automatic logic [63:0] expected_word(input logic [63:0] word, input int ew,
                                              input int cv, input int part);
  int          w;
  int          wo;
  int          n;
  int          e;
  logic        sgn;
  logic [63:0] src;
  logic [63:0] res;
  logic [63:0] lo_mask;
  logic [63:0] hi_mask;
  if (widen_factor(ew, cv) == 1) return word;
  w       = 8 << ew;
  wo      = w * widen_factor(ew, cv);
  n       = 64 / wo;
  sgn     = (cv == ConvSExt2) || (cv == ConvSExt4) || (cv == ConvSExt8);
  lo_mask = (64'd1 << w) - 64'd1;
  hi_mask = (wo == 64) ? '1 : ((64'd1 << wo) - 64'd1);
  res     = '0;
  for (e = 0; e < n; e++) begin
    src = (word >> ((part * n + e) * w)) & lo_mask;
    if (sgn && src[w-1]) src = src | ~lo_mask;
    res = res | ((src & hi_mask) << (e * wo));
  end
  return res;
endfunction

`endif

// ==== sim/tb_operand_queue.sv ====
////////////////////////////////////////
// Operand queue testbench
// Clock, reset, stimulus, scoreboard,
// checker task, timeout and summary
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module tb_operand_queue
  import opq_pkg::*;
();

  localparam int MaxCycles = 4000;

  logic                clk_i;
  logic                rst_ni;
  eew_e                cmd_eew_i;
  conv_e               cmd_conv_i;
  logic [VL_WIDTH-1:0] cmd_vl_i;
  logic                cmd_valid_i;
  logic [ELEN-1:0]     operand_i;
  logic                operand_valid_i;
  logic                operand_issued_i;
  logic                operand_ready_i;
  logic                operand_queue_ready_o;
  logic [ELEN-1:0]     operand_o;
  logic                operand_valid_o;

  int          seed = 38;
  int          errors;
  int          done_outs;
  int          cycle_cnt;
  bit          rand_ready;
  logic [63:0] exp_q[$];
  logic [63:0] early_q[$];
  int          cum_outs[$];

  `include "tb_ref.svh"

  operand_queue #(
    .BufferDepth (2)
  ) dut0 (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .cmd_eew_i             (cmd_eew_i),
    .cmd_conv_i            (cmd_conv_i),
    .cmd_vl_i              (cmd_vl_i),
    .cmd_valid_i           (cmd_valid_i),
    .operand_i             (operand_i),
    .operand_valid_i       (operand_valid_i),
    .operand_issued_i      (operand_issued_i),
    .operand_queue_ready_o (operand_queue_ready_o),
    .operand_o             (operand_o),
    .operand_valid_o       (operand_valid_o),
    .operand_ready_i       (operand_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic compare_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %h, got %h at %0t", name, exp, act, $time);
    end
  endtask

  function automatic logic [63:0] next_word();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic wait_outputs(input int n);
    while (done_outs < n) @(negedge clk_i);
  endtask

  // Issue strobe while credits are free, then deliver the word a cycle later
  task automatic send_word(input logic [63:0] w);
    @(negedge clk_i);
    while (!operand_queue_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    operand_issued_i <= 1'b1;
    @(posedge clk_i);
    operand_issued_i <= 1'b0;
    operand_i        <= w;
    operand_valid_i  <= 1'b1;
    @(posedge clk_i);
    operand_valid_i  <= 1'b0;
  endtask

  // Queue expected outputs, push the command, then send its words
  task automatic run_cmd(input int ew, input int cv, input int vl, input bit presend);
    int          n_out;
    int          f;
    int          idx;
    int          k;
    logic [63:0] words[$];
    n_out = output_count(ew, cv, vl);
    f     = widen_factor(ew, cv);
    for (k = 0; k < (n_out + f - 1) / f; k++) begin
      if (presend) words.push_back(early_q.pop_front());
      else words.push_back(next_word());
    end
    for (k = 0; k < n_out; k++) exp_q.push_back(expected_word(words[k / f], ew, cv, k % f));
    idx = cum_outs.size();
    cum_outs.push_back(((idx == 0) ? 0 : cum_outs[idx-1]) + n_out);
    // At most two commands pending in the command FIFO
    if (idx >= 2) wait_outputs(cum_outs[idx-2]);
    @(posedge clk_i);
    cmd_eew_i   <= eew_e'(ew);
    cmd_conv_i  <= conv_e'(cv);
    cmd_vl_i    <= VL_WIDTH'(vl);
    cmd_valid_i <= 1'b1;
    @(posedge clk_i);
    cmd_valid_i <= 1'b0;
    if (!presend) begin
      for (k = 0; k < words.size(); k++) send_word(words[k]);
    end
  endtask

  ////////////////////////////////////////
  // Output ready and compare processes
  ////////////////////////////////////////

  initial begin
    operand_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      operand_ready_i <= rand_ready ? (($random(seed) & 3) != 0) : 1'b1;
    end
  end

  // Valid and ready seen at the negedge mean a transfer on the next rising edge
  initial begin
    forever begin
      @(negedge clk_i);
      if (rst_ni && operand_valid_o && operand_ready_i) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Output word appeared with no expected word left at %0t", $time);
        end else begin
          compare_value("operand_o", exp_q.pop_front(), operand_o);
        end
        done_outs++;
      end
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MaxCycles) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Run stopped after %0d cycles with %0d outputs seen", cycle_cnt, done_outs);
    $display("RESULT: FAIL");
    $finish;
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    int ew;
    int cv;
    errors           = 0;
    done_outs        = 0;
    rand_ready       = 1'b0;
    rst_ni           = 1'b0;
    cmd_eew_i        = EW8;
    cmd_conv_i       = ConvNone;
    cmd_vl_i         = '0;
    cmd_valid_i      = 1'b0;
    operand_i        = '0;
    operand_valid_i  = 1'b0;
    operand_issued_i = 1'b0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    @(negedge clk_i);
    compare_value("operand_queue_ready_o", 64'd1, 64'(operand_queue_ready_o));
    compare_value("operand_valid_o", 64'd0, 64'(operand_valid_o));

    // Two words issued and no command, so every credit is taken
    early_q.push_back(next_word());
    early_q.push_back(next_word());
    send_word(early_q[0]);
    send_word(early_q[1]);
    @(negedge clk_i);
    compare_value("operand_queue_ready_o", 64'd0, 64'(operand_queue_ready_o));
    compare_value("operand_valid_o", 64'd0, 64'(operand_valid_o));
    run_cmd(EW64, ConvNone, 1, 1'b1);
    wait_outputs(1);
    @(negedge clk_i);
    compare_value("operand_queue_ready_o", 64'd1, 64'(operand_queue_ready_o));
    run_cmd(EW64, ConvNone, 1, 1'b1);

    // Plain pass-through, then an early end with random back-pressure
    run_cmd(EW32, ConvNone, 6, 1'b0);
    rand_ready = 1'b1;
    run_cmd(EW8, ConvZExt2, 5, 1'b0);
    run_cmd(EW64, ConvNone, 1, 1'b0);

    // Every supported sign and zero extension, random lengths
    repeat (2) begin
      for (cv = ConvSExt2; cv <= ConvZExt8; cv++) begin
        for (ew = EW8; ew <= EW64; ew++) begin
          if (widen_factor(ew, cv) > 1) run_cmd(ew, cv, 1 + ($random(seed) & 31), 1'b0);
        end
      end
    end
    // Unsupported pair falls back to pass-through
    run_cmd(EW32, ConvSExt8, 3, 1'b0);

    wait_outputs(cum_outs[cum_outs.size()-1]);
    repeat (3) @(negedge clk_i);
    compare_value("operand_valid_o", 64'd0, 64'(operand_valid_o));
    compare_value("operand_queue_ready_o", 64'd1, 64'(operand_queue_ready_o));
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected output words were never produced", exp_q.size());
    end

    $display("Summary: %0d outputs checked, %0d errors", done_outs, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+sim
src/opq_pkg.sv
src/opq_fifo.sv
src/opq_operand_buffer.sv
src/opq_extend_unit.sv
src/opq_issue_ctrl.sv
src/operand_queue.sv
sim/tb_operand_queue.sv

// ==== src/operand_queue.sv ====
////////////////////////////////////////
// Operand queue top level
// Command FIFO, operand buffer, extend
// unit and issue control
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module operand_queue
  import opq_pkg::*;
#(
  parameter int unsigned BufferDepth = 2
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Operand requester
  input  eew_e                cmd_eew_i,
  input  conv_e               cmd_conv_i,
  input  logic [VL_WIDTH-1:0] cmd_vl_i,
  input  logic                cmd_valid_i,
  // Register file
  input  logic [ELEN-1:0]     operand_i,
  input  logic                operand_valid_i,
  input  logic                operand_issued_i,
  output logic                operand_queue_ready_o,
  // Functional unit
  output logic [ELEN-1:0]     operand_o,
  output logic                operand_valid_o,
  input  logic                operand_ready_i
);

  opq_cmd_t        cmd_in;
  opq_cmd_t        cmd_head;
  logic            cmd_empty;
  logic            cmd_valid;
  logic            cmd_pop;
  logic [ELEN-1:0] word_head;
  logic            word_valid;
  logic            word_pop;
  logic [2:0]      part;

  assign cmd_in    = '{eew: cmd_eew_i, conv: cmd_conv_i, vl: cmd_vl_i};
  assign cmd_valid = !cmd_empty;

  opq_fifo #(
    .Depth (BufferDepth),
    .Width ($bits(opq_cmd_t))
  ) cmd_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (cmd_valid_i),
    .data_i  (cmd_in),
    .pop_i   (cmd_pop),
    .data_o  (cmd_head),
    .empty_o (cmd_empty),
    .full_o  ()
  );

  opq_operand_buffer #(
    .Depth (BufferDepth)
  ) operand_buffer (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .operand_i        (operand_i),
    .operand_valid_i  (operand_valid_i),
    .operand_issued_i (operand_issued_i),
    .pop_i            (word_pop),
    .word_o           (word_head),
    .word_valid_o     (word_valid),
    .ready_o          (operand_queue_ready_o)
  );

  opq_extend_unit extend_unit (
    .word_i (word_head),
    .eew_i  (cmd_head.eew),
    .conv_i (cmd_head.conv),
    .part_i (part),
    .word_o (operand_o)
  );

  opq_issue_ctrl issue_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd_i        (cmd_head),
    .cmd_valid_i  (cmd_valid),
    .word_valid_i (word_valid),
    .out_ready_i  (operand_ready_i),
    .part_o       (part),
    .out_valid_o  (operand_valid_o),
    .word_pop_o   (word_pop),
    .cmd_pop_o    (cmd_pop)
  );

endmodule

`default_nettype wire

// ==== src/opq_extend_unit.sv ====
////////////////////////////////////////
// Integer widening of one part of a word
// Sign or zero extension, factors 2/4/8
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module opq_extend_unit
  import opq_pkg::*;
(
  input  logic [ELEN-1:0] word_i,
  input  eew_e            eew_i,
  input  conv_e           conv_i,
  input  logic [2:0]      part_i,
  output logic [ELEN-1:0] word_o
);

  logic [1:0] ext_shift;
  logic       ext_sign;
  logic [5:0] base;

  assign ext_shift = conv_shift(eew_i, conv_i);
  assign ext_sign  = conv_signed(conv_i);

  // Bit offset of the first source element of this part: part * 64/F
  assign base = 6'({part_i, 3'b000} << (2'd3 - ext_shift));

  ////////////////////////////////////////
  // Element widening
  ////////////////////////////////////////

  always_comb begin
    logic [7:0]  src8;
    logic [15:0] src16;
    logic [31:0] src32;

    src8   = '0;
    src16  = '0;
    src32  = '0;
    // ConvNone and unsupported pairs pass the word through
    word_o = word_i;

    case ({eew_i, ext_shift})
      // 8 to 16 bits, four elements
      {EW8, 2'd1}: begin
        for (int e = 0; e < 4; e++) begin
          src8               = word_i[base + 8*e +: 8];
          word_o[16*e +: 16] = {{8{ext_sign & src8[7]}}, src8};
        end
      end
      // 8 to 32 bits, two elements
      {EW8, 2'd2}: begin
        for (int e = 0; e < 2; e++) begin
          src8               = word_i[base + 8*e +: 8];
          word_o[32*e +: 32] = {{24{ext_sign & src8[7]}}, src8};
        end
      end
      // 8 to 64 bits
      {EW8, 2'd3}: begin
        src8   = word_i[base +: 8];
        word_o = {{56{ext_sign & src8[7]}}, src8};
      end
      // 16 to 32 bits, two elements
      {EW16, 2'd1}: begin
        for (int e = 0; e < 2; e++) begin
          src16              = word_i[base + 16*e +: 16];
          word_o[32*e +: 32] = {{16{ext_sign & src16[15]}}, src16};
        end
      end
      // 16 to 64 bits
      {EW16, 2'd2}: begin
        src16  = word_i[base +: 16];
        word_o = {{48{ext_sign & src16[15]}}, src16};
      end
      // 32 to 64 bits
      {EW32, 2'd1}: begin
        src32  = word_i[base +: 32];
        word_o = {{32{ext_sign & src32[31]}}, src32};
      end
      default: begin
        word_o = word_i;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== src/opq_fifo.sv ====
////////////////////////////////////////
// Registered circular FIFO
// Depth and width set by parameters
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module opq_fifo #(
  parameter int unsigned Depth = 2,
  parameter int unsigned Width = 8
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  logic [Width-1:0] data_i,
  input  logic             pop_i,
  output logic [Width-1:0] data_o,
  output logic             empty_o,
  output logic             full_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  logic [Width-1:0]    mem_q [Depth];
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [CntWidth-1:0] count_q;

  // Wrap at Depth, which need not be a power of two
  function automatic logic [PtrWidth-1:0] ptr_next(logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(Depth - 1)) return '0;
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (pop_i) rd_ptr_q <= ptr_next(rd_ptr_q);
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_ptr_q] <= data_i;
  end

  assign data_o  = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CntWidth'(Depth));

  // A full FIFO only takes a word when the head leaves in the same cycle
  ap_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i && full_o |-> pop_i)
    else $error("opq_fifo: push while full");

  ap_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> !empty_o)
    else $error("opq_fifo: pop while empty");

endmodule

`default_nettype wire

// ==== src/opq_issue_ctrl.sv ====
////////////////////////////////////////
// Issue control
// Part pointer, element counter, and
// operand and command pop decisions
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module opq_issue_ctrl
  import opq_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  opq_cmd_t   cmd_i,
  input  logic       cmd_valid_i,
  input  logic       word_valid_i,
  input  logic       out_ready_i,
  output logic [2:0] part_o,
  output logic       out_valid_o,
  output logic       word_pop_o,
  output logic       cmd_pop_o
);

  logic [1:0]          shift;
  logic [3:0]          elems;
  logic [2:0]          last_part;
  logic [2:0]          part_d;
  logic [2:0]          part_q;
  logic [VL_WIDTH-1:0] cnt_d;
  logic [VL_WIDTH-1:0] cnt_q;
  logic [VL_WIDTH:0]   cnt_sum;
  logic                transfer;
  logic                cmd_done;

  assign shift = conv_shift(cmd_i.eew, cmd_i.conv);

  // Elements per transfer: elements of the source width in a word, over F
  assign elems     = 4'd8 >> ({1'b0, cmd_i.eew} + {1'b0, shift});
  assign last_part = 3'((4'd1 << shift) - 4'd1);

  assign out_valid_o = cmd_valid_i & word_valid_i;
  assign transfer    = out_valid_o & out_ready_i;

  // One extra bit keeps the compare right near the top of the vl range
  assign cnt_sum  = {1'b0, cnt_q} + elems;
  assign cmd_done = (cnt_sum >= {1'b0, cmd_i.vl});

  ////////////////////////////////////////
  // Next state and pops
  ////////////////////////////////////////

  always_comb begin
    part_d     = part_q;
    cnt_d      = cnt_q;
    word_pop_o = 1'b0;
    cmd_pop_o  = 1'b0;

    if (transfer) begin
      cnt_d  = cnt_sum[VL_WIDTH-1:0];
      part_d = part_q + 3'd1;

      // Last part of the word used up, ConvNone always lands here
      if (part_q == last_part) begin
        word_pop_o = 1'b1;
        part_d     = '0;
      end

      // vl reached, retire the command with its current word
      if (cmd_done) begin
        word_pop_o = 1'b1;
        cmd_pop_o  = 1'b1;
        part_d     = '0;
        cnt_d      = '0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      part_q <= '0;
      cnt_q  <= '0;
    end else begin
      part_q <= part_d;
      cnt_q  <= cnt_d;
    end
  end

  assign part_o = part_q;

  ap_vl_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_valid_i |-> cmd_i.vl != '0)
    else $error("opq_issue_ctrl: command with vl zero");

endmodule

`default_nettype wire

// ==== src/opq_operand_buffer.sv ====
////////////////////////////////////////
// Operand word buffer
// Word FIFO plus issue-credit counter
// that drives the ready level
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module opq_operand_buffer
  import opq_pkg::*;
#(
  parameter int unsigned Depth = 2
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic [ELEN-1:0] operand_i,
  input  logic            operand_valid_i,
  input  logic            operand_issued_i,
  input  logic            pop_i,
  output logic [ELEN-1:0] word_o,
  output logic            word_valid_o,
  output logic            ready_o
);

  localparam int unsigned CntWidth = $clog2(Depth + 1);

  logic                buf_empty;
  logic                buf_full;
  logic [CntWidth-1:0] credit_d;
  logic [CntWidth-1:0] credit_q;

  opq_fifo #(
    .Depth (Depth),
    .Width (ELEN)
  ) word_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (operand_valid_i),
    .data_i  (operand_i),
    .pop_i   (pop_i),
    .data_o  (word_o),
    .empty_o (buf_empty),
    .full_o  (buf_full)
  );

  assign word_valid_o = !buf_empty;

  ////////////////////////////////////////
  // Issue credits
  ////////////////////////////////////////

  // Counts words issued by the register file and not yet consumed,
  // whether still in flight or already buffered
  always_comb begin
    credit_d = credit_q;
    if (operand_issued_i) credit_d = credit_d + 1'b1;
    if (pop_i) credit_d = credit_d - 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= '0;
    end else begin
      credit_q <= credit_d;
    end
  end

  assign ready_o = (credit_q != CntWidth'(Depth));

  ap_credit_max: assert property (@(posedge clk_i) disable iff (!rst_ni)
    operand_issued_i && !pop_i |-> credit_q < Depth)
    else $error("opq_operand_buffer: credit count exceeds depth");

  ap_credit_min: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i && !operand_issued_i |-> credit_q != '0)
    else $error("opq_operand_buffer: credit count wraps below zero");

  // Every buffered word holds a credit, so a full FIFO means no free credit
  ap_full_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    buf_full |-> credit_q == CntWidth'(Depth))
    else $error("opq_operand_buffer: FIFO full with free credits");

endmodule

`default_nettype wire

// ==== src/opq_pkg.sv ====
////////////////////////////////////////
// Operand queue shared definitions
// Word and length widths, element width
// and conversion enums, command struct,
// widening helper functions
////////////////////////////////////////
`default_nettype none

package opq_pkg;

  localparam int unsigned ELEN     = 64;
  localparam int unsigned VL_WIDTH = 16;

  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } eew_e;

  typedef enum logic [2:0] {
    ConvNone  = 3'd0,
    ConvSExt2 = 3'd1,
    ConvZExt2 = 3'd2,
    ConvSExt4 = 3'd3,
    ConvZExt4 = 3'd4,
    ConvSExt8 = 3'd5,
    ConvZExt8 = 3'd6
  } conv_e;

  typedef struct packed {
    eew_e                eew;
    conv_e               conv;
    logic [VL_WIDTH-1:0] vl;
  } opq_cmd_t;

  // log2 of the widening factor, zero for ConvNone and unsupported pairs
  function automatic logic [1:0] conv_shift(eew_e eew, conv_e conv);
    logic [1:0] shift;
    shift = 2'd0;
    case (conv)
      ConvSExt2, ConvZExt2: if (eew != EW64) shift = 2'd1;
      ConvSExt4, ConvZExt4: if (eew == EW8 || eew == EW16) shift = 2'd2;
      ConvSExt8, ConvZExt8: if (eew == EW8) shift = 2'd3;
      default:              shift = 2'd0;
    endcase
    return shift;
  endfunction

  function automatic logic conv_signed(conv_e conv);
    return (conv == ConvSExt2) || (conv == ConvSExt4) || (conv == ConvSExt8);
  endfunction

endpackage

`default_nettype wire
